/* rtl/dlc_pkg.sv */
`default_nettype none

package dlc_pkg;

  // datapath widths
  localparam int unsigned sample_w   = 16;  // sample and packet word
  localparam int unsigned fifo_depth = 4;   // default buffer depth

  // configuration field widths
  localparam int unsigned cfg_lwl_w  = 4;   // level-width exponent, shift of 0..15
  localparam int unsigned cfg_bits_w = 5;   // step/time field widths, 0..31

  // register map, byte addresses
  localparam logic [7:0] addr_lwl       = 8'h00;
  localparam logic [7:0] addr_dlvl_bits = 8'h04;
  localparam logic [7:0] addr_dt_bits   = 8'h08;

  // encoder FSM
  typedef enum logic [1:0] {
    enc_run,       // consume samples, emit crossing packets
    enc_dlvl_ovf,  // drain remaining level steps, time 0
    enc_dt_ovf     // emit time-only packet once there is room
  } enc_state_e;

endpackage

`default_nettype wire

/* rtl/dlc_cfg_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface dlc_cfg_if import dlc_pkg::*; ();

  logic [cfg_lwl_w-1:0]  log_wl;     // level = sample >>> log_wl
  logic [cfg_bits_w-1:0] dlvl_bits;  // step field width, direction sits just above
  logic [sample_w-1:0]   mask_dlvl;  // ones in the low dlvl_bits bits
  logic [sample_w-1:0]   mask_dt;    // ones in the low dt_bits bits

  // register block side
  modport cfg_src (output log_wl, output dlvl_bits, output mask_dlvl, output mask_dt);

  // encoder side
  modport cfg_dst (input log_wl, input dlvl_bits, input mask_dlvl, input mask_dt);

endinterface

`default_nettype wire

/* rtl/dlc_cfg_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module dlc_cfg_regs import dlc_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        reg_valid_i,
  input  logic        reg_write_i,
  input  logic [7:0]  reg_addr_i,
  input  logic [31:0] reg_wdata_i,
  output logic [31:0] reg_rdata_o,
  output logic        reg_error_o,
  dlc_cfg_if.cfg_src  cfg
);

  logic [cfg_lwl_w-1:0]  log_wl_q;     // level-width exponent
  logic [cfg_bits_w-1:0] dlvl_bits_q;  // step field width
  logic [cfg_bits_w-1:0] dt_bits_q;    // time field width
  logic [31:0]           mask_dlvl_w;  // wide masks, upper bits dropped below
  logic [31:0]           mask_dt_w;

  // register writes, unmapped addresses are ignored
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      log_wl_q    <= '0;
      dlvl_bits_q <= '0;
      dt_bits_q   <= '0;
    end else if (reg_valid_i && reg_write_i) begin
      case (reg_addr_i)
        addr_lwl:       log_wl_q    <= reg_wdata_i[cfg_lwl_w-1:0];
        addr_dlvl_bits: dlvl_bits_q <= reg_wdata_i[cfg_bits_w-1:0];
        addr_dt_bits:   dt_bits_q   <= reg_wdata_i[cfg_bits_w-1:0];
        default: ;
      endcase
    end
  end

  // read-back and error, both same-cycle
  always_comb begin
    reg_rdata_o = '0;
    reg_error_o = 1'b0;
    if (reg_valid_i) begin
      case (reg_addr_i)
        addr_lwl:       reg_rdata_o[cfg_lwl_w-1:0]  = log_wl_q;
        addr_dlvl_bits: reg_rdata_o[cfg_bits_w-1:0] = dlvl_bits_q;
        addr_dt_bits:   reg_rdata_o[cfg_bits_w-1:0] = dt_bits_q;
        default:        reg_error_o = 1'b1;  // nothing mapped here
      endcase
    end
  end

  // widths of 16 or more saturate to all ones after truncation
  assign mask_dlvl_w = (32'd1 << dlvl_bits_q) - 32'd1;
  assign mask_dt_w   = (32'd1 << dt_bits_q) - 32'd1;

  assign cfg.log_wl    = log_wl_q;
  assign cfg.dlvl_bits = dlvl_bits_q;
  assign cfg.mask_dlvl = mask_dlvl_w[sample_w-1:0];
  assign cfg.mask_dt   = mask_dt_w[sample_w-1:0];

endmodule

`default_nettype wire

/* rtl/dlc_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module dlc_fifo #(
  parameter int unsigned depth = 4,
  parameter int unsigned width = 16
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  logic [width-1:0] data_i,
  output logic             full_o,
  input  logic             pop_i,
  output logic [width-1:0] data_o,
  output logic             empty_o
);

  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_w = $clog2(depth + 1);

  logic [width-1:0] mem_q [depth];  // circular storage
  logic [ptr_w-1:0] wptr_q;
  logic [ptr_w-1:0] rptr_q;
  logic [cnt_w-1:0] cnt_q;  // occupancy, 0..depth
  logic             do_push;
  logic             do_pop;

  assign full_o  = (cnt_q == cnt_w'(depth));
  assign empty_o = (cnt_q == '0);

  assign do_push = push_i && !full_o;   // dropped when full
  assign do_pop  = pop_i && !empty_o;   // dropped when empty

  assign data_o = mem_q[rptr_q];  // head visible without a pop

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (do_push) begin
        wptr_q <= (wptr_q == ptr_w'(depth - 1)) ? '0 : wptr_q + 1'b1;  // wrap for any depth
      end
      if (do_pop) begin
        rptr_q <= (rptr_q == ptr_w'(depth - 1)) ? '0 : rptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (do_pop && !do_push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/dlc_encoder.sv */
`timescale 1ns/1ns
`default_nettype none

module dlc_encoder import dlc_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [sample_w-1:0] smp_data_i,
  input  logic                smp_empty_i,
  output logic                smp_pop_o,
  input  logic                pkt_full_i,
  output logic                pkt_push_o,
  output logic [sample_w-1:0] pkt_data_o,
  dlc_cfg_if.cfg_dst          cfg
);

  enc_state_e state_q, state_d;

  logic signed [sample_w-1:0] lvl;        // level of the head sample
  logic [sample_w-1:0]        cur_lvl_q;  // last level that produced a packet
  logic [sample_w-1:0]        skip_q;     // samples since the last packet
  logic [sample_w:0]          rem_q;      // steps still owed during overflow
  logic                       dir_q;      // direction held across overflow packets
  logic [sample_w:0]          diff;       // lvl - cur, one extra bit so it never wraps
  logic [sample_w:0]          abs_diff;
  logic [sample_w:0]          mask_dlvl_x;
  logic                       xing;       // consumed sample changed level
  logic                       dlvl_ovf;   // step count does not fit the field
  logic                       ovf_last;   // remainder fits, this is the closing packet
  logic                       room;       // packet FIFO can take a word
  logic [sample_w-1:0]        f_time;
  logic [sample_w-1:0]        f_steps;
  logic                       f_dir;
  logic [31:0]                pkt_word;   // assembled before truncation

  assign room      = !pkt_full_i;
  assign smp_pop_o = !smp_empty_i && room && (state_q == enc_run);

  // arithmetic shift keeps negative samples on negative levels
  assign lvl = $signed(smp_data_i) >>> cfg.log_wl;

  assign diff     = {lvl[sample_w-1], lvl} - {cur_lvl_q[sample_w-1], cur_lvl_q};
  assign abs_diff = diff[sample_w] ? (~diff + 1'b1) : diff;
  assign mask_dlvl_x = {1'b0, cfg.mask_dlvl};

  assign xing     = smp_pop_o && (diff != '0);
  assign dlvl_ovf = xing && (abs_diff > mask_dlvl_x);
  // a zero-width step field could never drain the remainder
  assign ovf_last = (rem_q <= mask_dlvl_x) || (cfg.mask_dlvl == '0);

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      enc_run: begin
        if (dlvl_ovf) begin
          state_d = enc_dlvl_ovf;
        end else if (smp_pop_o && !xing && (skip_q == cfg.mask_dt)) begin
          state_d = enc_dt_ovf;  // skip counter at its limit
        end
      end
      enc_dlvl_ovf: if (room && ovf_last) state_d = enc_run;
      enc_dt_ovf:   if (room) state_d = enc_run;
      default:      state_d = enc_run;
    endcase
  end

  // packet fields and push
  always_comb begin
    pkt_push_o = 1'b0;
    f_time     = '0;
    f_steps    = '0;
    f_dir      = 1'b0;
    case (state_q)
      enc_run: begin
        pkt_push_o = xing;  // pop already implies room
        f_time     = skip_q & cfg.mask_dt;
        f_dir      = diff[sample_w];  // 1 means downward
        f_steps    = dlvl_ovf ? cfg.mask_dlvl : abs_diff[sample_w-1:0];
      end
      enc_dlvl_ovf: begin
        pkt_push_o = room;
        f_dir      = dir_q;  // time stays 0, same instant
        f_steps    = ovf_last ? (rem_q[sample_w-1:0] & cfg.mask_dlvl) : cfg.mask_dlvl;
      end
      enc_dt_ovf: begin
        pkt_push_o = room;
        f_time     = cfg.mask_dt;  // time-only, no steps
      end
      default: ;
    endcase
  end

  // time above direction above steps, anything past 16 bits falls off
  assign pkt_word   = ({15'd0, f_time, f_dir} << cfg.dlvl_bits) | {16'd0, f_steps};
  assign pkt_data_o = pkt_word[sample_w-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= enc_run;
      cur_lvl_q <= '0;
      skip_q    <= '0;
      rem_q     <= '0;
      dir_q     <= 1'b0;
    end else begin
      state_q <= state_d;
      if (xing) begin
        cur_lvl_q <= lvl;  // overflow packets owe nothing more to cur
      end
      if ((state_q == enc_dt_ovf && room) || xing) begin
        skip_q <= sample_w'(1);
      end else if (smp_pop_o) begin
        skip_q <= skip_q + 1'b1;
      end
      if (dlvl_ovf) begin
        rem_q <= abs_diff - mask_dlvl_x;  // first packet took one full field
        dir_q <= diff[sample_w];
      end else if (state_q == enc_dlvl_ovf && room) begin
        rem_q <= ovf_last ? '0 : rem_q - mask_dlvl_x;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/dlc_top.sv */
`timescale 1ns/1ns
`default_nettype none

module dlc_top import dlc_pkg::*; #(
  parameter int unsigned fifo_depth = dlc_pkg::fifo_depth
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                reg_valid_i,
  input  logic                reg_write_i,
  input  logic [7:0]          reg_addr_i,
  input  logic [31:0]         reg_wdata_i,
  output logic [31:0]         reg_rdata_o,
  output logic                reg_error_o,
  input  logic                in_push_i,
  input  logic [sample_w-1:0] in_data_i,
  output logic                in_full_o,
  input  logic                out_pop_i,
  output logic [sample_w-1:0] out_data_o,
  output logic                out_empty_o
);

  logic [sample_w-1:0] smp_data;  // sample FIFO head
  logic                smp_empty;
  logic                smp_pop;
  logic [sample_w-1:0] pkt_data;  // encoder output word
  logic                pkt_full;
  logic                pkt_push;

  dlc_cfg_if cfg_bus ();

  dlc_cfg_regs i_cfg_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .reg_valid_i (reg_valid_i),
    .reg_write_i (reg_write_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .reg_error_o (reg_error_o),
    .cfg         (cfg_bus.cfg_src)
  );

  // producer side buffer
  dlc_fifo #(.depth(fifo_depth), .width(sample_w)) i_sample_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (in_push_i),
    .data_i  (in_data_i),
    .full_o  (in_full_o),
    .pop_i   (smp_pop),
    .data_o  (smp_data),
    .empty_o (smp_empty)
  );

  dlc_encoder i_encoder (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .smp_data_i  (smp_data),
    .smp_empty_i (smp_empty),
    .smp_pop_o   (smp_pop),
    .pkt_full_i  (pkt_full),
    .pkt_push_o  (pkt_push),
    .pkt_data_o  (pkt_data),
    .cfg         (cfg_bus.cfg_dst)
  );

  // consumer side buffer
  dlc_fifo #(.depth(fifo_depth), .width(sample_w)) i_packet_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (pkt_push),
    .data_i  (pkt_data),
    .full_o  (pkt_full),
    .pop_i   (out_pop_i),
    .data_o  (out_data_o),
    .empty_o (out_empty_o)
  );

endmodule

`default_nettype wire

/* testbench/dlc_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module dlc_checker (
  input logic clk_i,
  input logic rst_ni,
  input logic smp_pop_i,    // encoder pops the sample FIFO
  input logic smp_empty_i,
  input logic pkt_push_i,   // encoder pushes the packet FIFO
  input logic pkt_full_i,
  input logic out_empty_i,
  input logic reg_valid_i,
  input logic reg_error_i
);

  // failure counts per assertion
  int unsigned n_push = 0;
  int unsigned n_pop = 0;
  int unsigned n_rst = 0;
  int unsigned n_err = 0;
  int unsigned fail_cnt;

  assign fail_cnt = n_push + n_pop + n_rst + n_err;

  no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(pkt_push_i && pkt_full_i)) else begin
    $error("packet pushed into a full packet FIFO");
    n_push++;
  end

  no_pop_when_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(smp_pop_i && smp_empty_i)) else begin
    $error("sample popped from an empty sample FIFO");
    n_pop++;
  end

  // first sampled edge out of reset
  empty_after_reset: assert property (@(posedge clk_i) $rose(rst_ni) |-> out_empty_i) else begin
    $error("output FIFO not empty right after reset");
    n_rst++;
  end

  error_needs_valid: assert property (@(posedge clk_i) reg_error_i |-> reg_valid_i) else begin
    $error("register error flag raised without a valid access");
    n_err++;
  end

endmodule

`default_nettype wire

/* testbench/dlc_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module dlc_tb import dlc_pkg::*; ();

  localparam int clk_period  = 40;
  localparam int drive_delay = 5;     // inputs change this long after the rising edge
  localparam int seed_init   = 86365;
  localparam int timeout_cyc = 4000;  // about 45 samples of a few cycles each plus idle gaps

  logic clk, rst_n, reg_valid, reg_write, reg_error, in_push, in_full, out_pop, out_empty;
  logic [7:0]  reg_addr;
  logic [31:0] reg_wdata, reg_rdata;
  logic [15:0] in_data, out_data;
  logic [15:0] exp_q [$];  // packets the model predicts, oldest first
  int seed, cycles, errors, tests_run, tests_bad, test_err0;
  int m_cur, m_skip, m_lwl, m_dbits, m_tbits;  // model state and config mirror
  int n_bp;  // samples pushed before in_full rose
  bit push_done;
  string test_name;

  dlc_top #(.fifo_depth(fifo_depth)) i_dlc_top (
    .clk_i(clk), .rst_ni(rst_n), .reg_valid_i(reg_valid), .reg_write_i(reg_write),
    .reg_addr_i(reg_addr), .reg_wdata_i(reg_wdata), .reg_rdata_o(reg_rdata),
    .reg_error_o(reg_error), .in_push_i(in_push), .in_data_i(in_data), .in_full_o(in_full),
    .out_pop_i(out_pop), .out_data_o(out_data), .out_empty_o(out_empty)
  );

  bind dlc_top dlc_checker i_checker (
    .clk_i(clk_i), .rst_ni(rst_ni), .smp_pop_i(smp_pop), .smp_empty_i(smp_empty),
    .pkt_push_i(pkt_push), .pkt_full_i(pkt_full), .out_empty_i(out_empty_o),
    .reg_valid_i(reg_valid_i), .reg_error_i(reg_error_o)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= timeout_cyc) begin
      $display("timeout after %0d cycles, the DUT stopped producing packets", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  task next_cycle;
    @(posedge clk);
    #drive_delay;
  endtask

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("** Error %s %s: expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
      errors++;
    end
  endtask

  function automatic int mask_of(input int bits);
    return (1 << bits) - 1;
  endfunction

  // time above direction above steps cut to one word
  function automatic logic [15:0] pack(input int t, input int dir, input int steps);
    int word;
    word = ((t & mask_of(m_tbits)) << (m_dbits + 1)) | (dir << m_dbits) | steps;
    return 16'(word);
  endfunction

  // reference model called once per sample in push order
  task automatic model_sample(input logic [15:0] s);
    int lvl, d, mag, dir, step;
    lvl = int'($signed(s));
    lvl = lvl >>> m_lwl;
    d = lvl - m_cur;
    if (d == 0) begin
      if (m_skip == mask_of(m_tbits)) begin
        exp_q.push_back(pack(mask_of(m_tbits), 0, 0));  // time-only
        m_skip = 1;
      end else begin
        m_skip++;
      end
    end else begin
      dir = (d < 0) ? 1 : 0;
      mag = (d < 0) ? -d : d;
      step = (mag > mask_of(m_dbits)) ? mask_of(m_dbits) : mag;
      exp_q.push_back(pack(m_skip, dir, step));
      mag -= step;
      while (mag > 0) begin  // overflow packets share the instant
        step = (mag > mask_of(m_dbits)) ? mask_of(m_dbits) : mag;
        exp_q.push_back(pack(0, dir, step));
        mag -= step;
      end
      m_skip = 1;
      m_cur = lvl;
    end
  endtask

  task automatic write_reg(input logic [7:0] a, input int d);
    reg_valid = 1'b1;
    reg_write = 1'b1;
    reg_addr = a;
    reg_wdata = d;
    next_cycle();
    reg_valid = 1'b0;
    reg_write = 1'b0;
  endtask

  task automatic check_read(input logic [7:0] a, input int exp);
    reg_valid = 1'b1;
    reg_addr = a;
    #1;
    check_eq($sformatf("read 0x%0h", a), exp, reg_rdata);
    next_cycle();
    reg_valid = 1'b0;
  endtask

  task automatic configure(input int lwl, input int dbits, input int tbits);
    write_reg(addr_lwl, lwl);
    write_reg(addr_dlvl_bits, dbits);
    write_reg(addr_dt_bits, tbits);
    m_lwl = lwl;
    m_dbits = dbits;
    m_tbits = tbits;
  endtask

  task automatic push_level(input int lvl);
    logic [15:0] s;
    s = 16'((lvl <<< m_lwl) + ($unsigned($random(seed)) % (1 << m_lwl)));  // random fraction
    while (in_full) next_cycle();
    in_push = 1'b1;
    in_data = s;
    model_sample(s);
    next_cycle();
    in_push = 1'b0;
  endtask

  // pop and compare until the pusher is done and nothing is owed
  task automatic drain_packets;
    logic [15:0] exp;
    while (!push_done || exp_q.size() != 0) begin
      out_pop = 1'b0;
      if (!out_empty) begin
        assert (exp_q.size() != 0) else begin
          $display("%s: DUT produced a packet the model did not expect", test_name);
          errors++;
        end
        if (exp_q.size() != 0) begin
          exp = exp_q.pop_front();
          check_eq("packet", exp, out_data);
        end
        out_pop = 1'b1;
      end
      next_cycle();
    end
    out_pop = 1'b0;
    repeat (8) next_cycle();  // long enough for a stray packet to surface
    assert (out_empty) else begin
      $display("%s: output FIFO still holds a packet nobody expected", test_name);
      errors++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_err0 = errors;
    push_done = 1'b0;
  endtask

  task automatic end_test;
    tests_run++;
    if (errors != test_err0) begin
      tests_bad++;
      $display("test %s: %0d error(s)", test_name, errors - test_err0);
    end else begin
      $display("test %s: ok", test_name);
    end
  endtask

  initial begin
    {reg_valid, reg_write, reg_addr, reg_wdata, in_push, in_data, out_pop} = '0;
    rst_n = 1'b0;
    seed = seed_init;
    {cycles, errors, tests_run, tests_bad, m_cur, m_skip, m_lwl, m_dbits, m_tbits} = '0;
    repeat (10) @(posedge clk);
    #drive_delay;
    rst_n = 1'b1;
    next_cycle();

    begin_test("registers");
    configure(3, 5, 6);
    check_read(addr_lwl, 3);
    check_read(addr_dlvl_bits, 5);
    check_read(addr_dt_bits, 6);
    reg_valid = 1'b1;
    reg_addr = 8'h0c;  // unmapped
    #1;
    assert (reg_error) else begin
      $display("%s: unmapped address 0xC did not raise the error flag", test_name);
      errors++;
    end
    next_cycle();
    reg_valid = 1'b0;
    end_test();

    begin_test("plain_crossings");
    configure(4, 4, 8);
    fork
      begin
        repeat (20) push_level(m_cur + ($random(seed) % 8));  // steps of -7..7
        push_done = 1'b1;
      end
      drain_packets();
    join
    end_test();

    begin_test("level_overflow");
    fork
      begin
        push_level(m_cur + 40);  // splits into 15 15 10 upward
        push_level(m_cur - 40);  // same split downward
        push_done = 1'b1;
      end
      drain_packets();
    join
    end_test();

    begin_test("time_overflow");
    configure(4, 4, 3);
    fork
      begin
        push_level(m_cur + 1);
        repeat (11) push_level(m_cur);  // skip count passes 7
        push_level(m_cur + 2);
        push_done = 1'b1;
      end
      drain_packets();
    join
    end_test();

    begin_test("back_pressure");
    configure(4, 4, 8);
    n_bp = 0;
    while (!in_full) begin  // nobody pops so both FIFOs fill up
      push_level((m_cur > 0) ? m_cur - 1 - ($unsigned($random(seed)) % 5)
                             : m_cur + 1 + ($unsigned($random(seed)) % 5));
      n_bp++;
    end
    // four queued packets plus four waiting samples
    check_eq("samples until in_full", 2 * fifo_depth, n_bp);
    push_done = 1'b1;
    drain_packets();
    end_test();

    errors += int'(i_dlc_top.i_checker.fail_cnt);
    $display("tests run %0d, tests with errors %0d, checks failed %0d", tests_run, tests_bad,
             errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
rtl/dlc_pkg.sv
rtl/dlc_cfg_if.sv
rtl/dlc_cfg_regs.sv
rtl/dlc_fifo.sv
rtl/dlc_encoder.sv
rtl/dlc_top.sv
testbench/dlc_checker.sv
testbench/dlc_tb.sv

/* run.sh */
#!/usr/bin/env bash
# compile with Verilator, run, and pass only if the pass line appears in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module dlc_tb -o sim_dlc || exit 1
out="$(./obj_dir/sim_dlc +verilator+error+limit+100)"
echo "$out"
echo "$out" | grep -qx "Simulation completed successfully" && echo "PASS" || { echo "FAIL"; exit 1; }
